//--- hw/reg_bus_pkg.sv
// Register bus package: bus widths, block select codes and per-block register offsets
package reg_bus_pkg;

   // --------------------------------------
   // Bus widths
   // --------------------------------------
   // Byte address, 1 KB register window
   localparam int REG_ADDR_W  = 10;
   localparam int REG_DATA_W  = 32;
   localparam int REG_BE_W    = REG_DATA_W / 8;

   // Address bits 9:7 pick the block
   localparam int BLK_SEL_LSB = 7;
   localparam int BLK_SEL_W   = 3;

   // Address bits 6:2 pick the word inside a block
   localparam int WORD_OFS_W  = BLK_SEL_LSB - 2;

   // Block codes, anything not listed is unmapped
   typedef enum logic [BLK_SEL_W-1:0] {
      SEL_GPIO = 3'd1,
      SEL_SEMA = 3'd4,
      SEL_D2A  = 3'd6
   } blk_sel_t;

   typedef logic [REG_DATA_W-1:0] reg_data_t;
   typedef logic [REG_BE_W-1:0]   reg_be_t;
   typedef logic [WORD_OFS_W-1:0] word_ofs_t;

   // --------------------------------------
   // Register offsets, in words
   // --------------------------------------
   // GPIO block
   localparam word_ofs_t GPIO_DIR_OFS    = 5'd0;
   localparam word_ofs_t GPIO_OUT_OFS    = 5'd1;
   // Read only, synchronized pad inputs
   localparam word_ofs_t GPIO_IN_OFS     = 5'd2;
   localparam word_ofs_t GPIO_MFS_OFS    = 5'd3;

   // Semaphore block, lock vector at 0 and semaphore n at offset n
   localparam word_ofs_t SEMA_STATUS_OFS = 5'd0;
   localparam int        SEMA_COUNT      = 15;

   // DAC mux select block
   localparam word_ofs_t D2A_SEL_OFS     = 5'd0;

endpackage

//--- hw/pad_pkg.sv
// Pad package: pad count, GPIO width, UART pad positions and DAC select types
package pad_pkg;

   // --------------------------------------
   // Digital pads
   // --------------------------------------
   localparam int PAD_COUNT    = 16;
   // One GPIO bit per pad
   localparam int GPIO_W       = 16;

   typedef logic [PAD_COUNT-1:0] pad_vec_t;

   // UART pads, used when the UART function is selected
   localparam int UART_RXD_PAD = 14;
   localparam int UART_TXD_PAD = 15;

   // Bit of the multi-function select that enables the UART
   localparam int MFS_UART_BIT = 0;

   // --------------------------------------
   // DAC mux selects
   // --------------------------------------
   localparam int DAC_SEL_W    = 8;
   localparam int DAC_COUNT    = 4;

   // Entry k is the select of DAC k, packed into one bus word
   typedef logic [DAC_COUNT-1:0][DAC_SEL_W-1:0] dac_sel_arr_t;

endpackage

//--- hw/reg_blk_decode.sv
// Register block decoder: block chip selects, latched block code and response mux
`timescale 1ns/10ps

module reg_blk_decode (
   input  logic                                mclk,
   input  logic                                s_reset_ssn,
   input  logic                                reg_cs_i,
   input  logic [reg_bus_pkg::REG_ADDR_W-1:0]  reg_addr_i,
   input  reg_bus_pkg::reg_data_t              gpio_rdata_i,
   input  logic                                gpio_ack_i,
   input  reg_bus_pkg::reg_data_t              sema_rdata_i,
   input  logic                                sema_ack_i,
   input  reg_bus_pkg::reg_data_t              d2a_rdata_i,
   input  logic                                d2a_ack_i,
   output logic                                gpio_cs_o,
   output logic                                sema_cs_o,
   output logic                                d2a_cs_o,
   output reg_bus_pkg::reg_data_t              reg_rdata_o,
   output logic                                reg_ack_o
);

   import reg_bus_pkg::*;

   blk_sel_t  blk_code;
   blk_sel_t  blk_sel_q;
   logic      blk_mapped;
   logic      unmap_ack_q;

   // Block field of the current address
   assign blk_code   = blk_sel_t'(reg_addr_i[BLK_SEL_LSB +: BLK_SEL_W]);
   assign blk_mapped = (blk_code == SEL_GPIO) | (blk_code == SEL_SEMA) | (blk_code == SEL_D2A);

   // One chip select per block
   assign gpio_cs_o  = reg_cs_i & (blk_code == SEL_GPIO);
   assign sema_cs_o  = reg_cs_i & (blk_code == SEL_SEMA);
   assign d2a_cs_o   = reg_cs_i & (blk_code == SEL_D2A);

   // Block code held for the response cycle, plus own ack for holes in the map
   always_ff @(posedge mclk or negedge s_reset_ssn) begin
      if (!s_reset_ssn) begin
         blk_sel_q   <= blk_sel_t'('0);
         unmap_ack_q <= 1'b0;
      end else begin
         if (reg_cs_i) begin
            blk_sel_q <= blk_code;
         end
         // Single pulse, ignores cs during its own ack cycle
         unmap_ack_q <= reg_cs_i & ~blk_mapped & ~unmap_ack_q;
      end
   end

   // --------------------------------------
   // Response mux
   // --------------------------------------
   always_comb begin
      case (blk_sel_q)
         SEL_GPIO: begin
            reg_rdata_o = gpio_rdata_i;
            reg_ack_o   = gpio_ack_i;
         end
         SEL_SEMA: begin
            reg_rdata_o = sema_rdata_i;
            reg_ack_o   = sema_ack_i;
         end
         SEL_D2A: begin
            reg_rdata_o = d2a_rdata_i;
            reg_ack_o   = d2a_ack_i;
         end
         // Unmapped, zero data
         default: begin
            reg_rdata_o = '0;
            reg_ack_o   = unmap_ack_q;
         end
      endcase
   end

   a_one_cs : assert property (@(posedge mclk) disable iff (!s_reset_ssn)
      $onehot0({gpio_cs_o, sema_cs_o, d2a_cs_o}))
      else $error("more than one block chip select active");

   a_ack_pulse : assert property (@(posedge mclk) disable iff (!s_reset_ssn)
      reg_ack_o |=> !reg_ack_o)
      else $error("reg_ack_o high for two cycles");

endmodule

//--- hw/gpio_reg.sv
// GPIO register block: direction, output, synchronized input and multi-function select
`timescale 1ns/10ps

module gpio_reg (
   input  logic                     mclk,
   input  logic                     s_reset_ssn,
   input  logic                     reg_cs_i,
   input  logic                     reg_wr_i,
   input  reg_bus_pkg::word_ofs_t   reg_ofs_i,
   input  reg_bus_pkg::reg_data_t   reg_wdata_i,
   input  reg_bus_pkg::reg_be_t     reg_be_i,
   input  pad_pkg::pad_vec_t        pad_gpio_in_i,
   output reg_bus_pkg::reg_data_t   reg_rdata_o,
   output logic                     reg_ack_o,
   output pad_pkg::pad_vec_t        cfg_gpio_dir_sel_o,
   output pad_pkg::pad_vec_t        gpio_out_o,
   output pad_pkg::pad_vec_t        cfg_multi_func_sel_o
);

   import reg_bus_pkg::*;
   import pad_pkg::*;

   // Byte lanes covered by a GPIO word
   localparam int GPIO_BYTES = GPIO_W / 8;

   logic [GPIO_W-1:0]  dir_q;
   logic [GPIO_W-1:0]  out_q;
   logic [GPIO_W-1:0]  mfs_q;
   // Pad input synchronizer
   logic [GPIO_W-1:0]  sync1_q;
   logic [GPIO_W-1:0]  sync2_q;
   logic               ack_q;
   logic               acc_en;
   logic               wr_en;
   logic               rd_en;
   reg_data_t          rd_word;
   reg_data_t          rdata_q;

   // Accept cs only outside our own ack cycle
   assign acc_en = reg_cs_i & ~ack_q;
   assign wr_en  = acc_en & reg_wr_i;
   assign rd_en  = acc_en & ~reg_wr_i;

   // --------------------------------------
   // Writable registers
   // --------------------------------------
   always_ff @(posedge mclk or negedge s_reset_ssn) begin
      if (!s_reset_ssn) begin
         dir_q <= '0;
         out_q <= '0;
         mfs_q <= '0;
      end else if (wr_en) begin
         for (int b = 0; b < GPIO_BYTES; b++) begin
            if (reg_be_i[b]) begin
               case (reg_ofs_i)
                  GPIO_DIR_OFS: dir_q[8*b +: 8] <= reg_wdata_i[8*b +: 8];
                  GPIO_OUT_OFS: out_q[8*b +: 8] <= reg_wdata_i[8*b +: 8];
                  GPIO_MFS_OFS: mfs_q[8*b +: 8] <= reg_wdata_i[8*b +: 8];
                  // GPIO_IN and holes ignore writes
                  default: ;
               endcase
            end
         end
      end
   end

   // Two flops on the pad side
   always_ff @(posedge mclk) begin
      sync1_q <= pad_gpio_in_i;
      sync2_q <= sync1_q;
   end

   // Readback word, zero extended
   always_comb begin
      rd_word = '0;
      case (reg_ofs_i)
         GPIO_DIR_OFS: rd_word[GPIO_W-1:0] = dir_q;
         GPIO_OUT_OFS: rd_word[GPIO_W-1:0] = out_q;
         GPIO_IN_OFS:  rd_word[GPIO_W-1:0] = sync2_q;
         GPIO_MFS_OFS: rd_word[GPIO_W-1:0] = mfs_q;
         default:      rd_word = '0;
      endcase
   end

   // Ack and read data leave together
   always_ff @(posedge mclk or negedge s_reset_ssn) begin
      if (!s_reset_ssn) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= acc_en;
      end
   end

   always_ff @(posedge mclk) begin
      if (rd_en) begin
         rdata_q <= rd_word;
      end
   end

   assign reg_rdata_o          = rdata_q;
   assign reg_ack_o            = ack_q;
   assign cfg_gpio_dir_sel_o   = dir_q;
   assign gpio_out_o           = out_q;
   assign cfg_multi_func_sel_o = mfs_q;

   // Ack one cycle after cs, then cs released
   a_gpio_ack : assert property (@(posedge mclk) disable iff (!s_reset_ssn)
      $rose(reg_cs_i) |=> reg_ack_o ##1 !reg_cs_i)
      else $error("GPIO access not closed by a one-cycle ack");

endmodule

//--- hw/pad_mux.sv
// Pad multiplexer: routes GPIO bits and the UART onto the digital pads
`timescale 1ns/10ps

module pad_mux (
   input  pad_pkg::pad_vec_t  cfg_gpio_dir_sel_i,
   input  pad_pkg::pad_vec_t  gpio_out_i,
   input  pad_pkg::pad_vec_t  cfg_multi_func_sel_i,
   input  logic               uart_txd_i,
   input  pad_pkg::pad_vec_t  digital_io_in_i,
   output pad_pkg::pad_vec_t  digital_io_out_o,
   output pad_pkg::pad_vec_t  digital_io_oen_o,
   output pad_pkg::pad_vec_t  pad_gpio_in_o,
   output logic               uart_rxd_o
);

   import pad_pkg::*;

   logic uart_en;

   assign uart_en = cfg_multi_func_sel_i[MFS_UART_BIT];

   // --------------------------------------
   // Pad output side
   // --------------------------------------
   always_comb begin
      // GPIO default, oen low only where direction is output
      digital_io_out_o = gpio_out_i;
      digital_io_oen_o = ~cfg_gpio_dir_sel_i;

      if (uart_en) begin
         // TXD pad driven by the UART
         digital_io_out_o[UART_TXD_PAD] = uart_txd_i;
         digital_io_oen_o[UART_TXD_PAD] = 1'b0;
         // RXD pad held as input, whatever the GPIO direction says
         digital_io_out_o[UART_RXD_PAD] = 1'b0;
         digital_io_oen_o[UART_RXD_PAD] = 1'b1;
      end
   end

   // Pad inputs always reach the GPIO synchronizer
   assign pad_gpio_in_o = digital_io_in_i;

   // Idle line level when the UART is not on its pads
   assign uart_rxd_o = uart_en ? digital_io_in_i[UART_RXD_PAD] : 1'b1;

endmodule

//--- hw/semaphore_reg.sv
// Hardware semaphore block: fifteen locks taken by read and freed by write
`timescale 1ns/10ps

module semaphore_reg (
   input  logic                     mclk,
   input  logic                     s_reset_ssn,
   input  logic                     reg_cs_i,
   input  logic                     reg_wr_i,
   input  reg_bus_pkg::word_ofs_t   reg_ofs_i,
   input  reg_bus_pkg::reg_data_t   reg_wdata_i,
   output reg_bus_pkg::reg_data_t   reg_rdata_o,
   output logic                     reg_ack_o
);

   import reg_bus_pkg::*;

   // Lock n lives at bit n, bit 0 does not exist
   logic [SEMA_COUNT:1]  lock_q;
   logic                 ack_q;
   logic                 acc_en;
   logic                 rd_en;
   logic                 sema_hit;
   reg_data_t            rd_word;
   reg_data_t            rdata_q;

   assign acc_en   = reg_cs_i & ~ack_q;
   assign rd_en    = acc_en & ~reg_wr_i;
   // Offsets 1 to SEMA_COUNT address a semaphore
   assign sema_hit = (reg_ofs_i != SEMA_STATUS_OFS) && (reg_ofs_i <= SEMA_COUNT);

   // --------------------------------------
   // Lock bits
   // --------------------------------------
   always_ff @(posedge mclk or negedge s_reset_ssn) begin
      if (!s_reset_ssn) begin
         lock_q <= '0;
      end else if (acc_en && sema_hit) begin
         if (reg_wr_i) begin
            // Release only with data bit 0 set
            if (reg_wdata_i[0]) begin
               lock_q[reg_ofs_i] <= 1'b0;
            end
         end else begin
            // Read always leaves the lock taken
            lock_q[reg_ofs_i] <= 1'b1;
         end
      end
   end

   // Status vector or acquire result
   always_comb begin
      rd_word = '0;
      if (reg_ofs_i == SEMA_STATUS_OFS) begin
         rd_word[SEMA_COUNT:1] = lock_q;
      end else if (sema_hit) begin
         // 1 means the caller got the lock
         rd_word[0] = ~lock_q[reg_ofs_i];
      end
   end

   always_ff @(posedge mclk or negedge s_reset_ssn) begin
      if (!s_reset_ssn) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= acc_en;
      end
   end

   // Sampled before the lock update of the same edge
   always_ff @(posedge mclk) begin
      if (rd_en) begin
         rdata_q <= rd_word;
      end
   end

   assign reg_rdata_o = rdata_q;
   assign reg_ack_o   = ack_q;

   // Ack one cycle after cs, then cs released
   a_sema_ack : assert property (@(posedge mclk) disable iff (!s_reset_ssn)
      $rose(reg_cs_i) |=> reg_ack_o ##1 !reg_cs_i)
      else $error("semaphore access not closed by a one-cycle ack");

endmodule

//--- hw/dig2ana_reg.sv
// DAC mux select block: one byte-writable word holding four DAC selects
`timescale 1ns/10ps

module dig2ana_reg (
   input  logic                     mclk,
   input  logic                     s_reset_ssn,
   input  logic                     reg_cs_i,
   input  logic                     reg_wr_i,
   input  reg_bus_pkg::word_ofs_t   reg_ofs_i,
   input  reg_bus_pkg::reg_data_t   reg_wdata_i,
   input  reg_bus_pkg::reg_be_t     reg_be_i,
   output reg_bus_pkg::reg_data_t   reg_rdata_o,
   output logic                     reg_ack_o,
   output pad_pkg::dac_sel_arr_t    cfg_dac_mux_sel_o
);

   import reg_bus_pkg::*;
   import pad_pkg::*;

   dac_sel_arr_t  sel_q;
   logic          ack_q;
   logic          acc_en;
   logic          sel_hit;
   reg_data_t     rdata_q;

   assign acc_en  = reg_cs_i & ~ack_q;
   assign sel_hit = (reg_ofs_i == D2A_SEL_OFS);

   // Byte k of the word is the select of DAC k
   always_ff @(posedge mclk or negedge s_reset_ssn) begin
      if (!s_reset_ssn) begin
         sel_q <= '0;
         ack_q <= 1'b0;
      end else begin
         ack_q <= acc_en;
         if (acc_en && reg_wr_i && sel_hit) begin
            for (int k = 0; k < DAC_COUNT; k++) begin
               if (reg_be_i[k]) begin
                  sel_q[k] <= reg_wdata_i[k*DAC_SEL_W +: DAC_SEL_W];
               end
            end
         end
      end
   end

   // Readback, other offsets zero
   always_ff @(posedge mclk) begin
      if (acc_en && !reg_wr_i) begin
         rdata_q <= sel_hit ? reg_data_t'(sel_q) : '0;
      end
   end

   assign reg_rdata_o       = rdata_q;
   assign reg_ack_o         = ack_q;
   assign cfg_dac_mux_sel_o = sel_q;

   // Ack one cycle after cs, then cs released
   a_d2a_ack : assert property (@(posedge mclk) disable iff (!s_reset_ssn)
      $rose(reg_cs_i) |=> reg_ack_o ##1 !reg_cs_i)
      else $error("DAC select access not closed by a one-cycle ack");

endmodule

//--- hw/pinmux_top.sv
// Pinmux top: register block decoder, GPIO, semaphore and DAC select blocks, pad mux
`timescale 1ns/10ps

module pinmux_top (
   input  logic                                 mclk,
   input  logic                                 s_reset_ssn,
   // Register bus
   input  logic                                 reg_cs_i,
   input  logic                                 reg_wr_i,
   input  logic [reg_bus_pkg::REG_ADDR_W-1:0]   reg_addr_i,
   input  reg_bus_pkg::reg_data_t               reg_wdata_i,
   input  reg_bus_pkg::reg_be_t                 reg_be_i,
   output reg_bus_pkg::reg_data_t               reg_rdata_o,
   output logic                                 reg_ack_o,
   // Digital pads
   input  pad_pkg::pad_vec_t                    digital_io_in_i,
   output pad_pkg::pad_vec_t                    digital_io_out_o,
   output pad_pkg::pad_vec_t                    digital_io_oen_o,
   // UART
   input  logic                                 uart_txd_i,
   output logic                                 uart_rxd_o,
   // DAC mux selects
   output pad_pkg::dac_sel_arr_t                cfg_dac_mux_sel_o
);

   import reg_bus_pkg::*;
   import pad_pkg::*;

   // Block chip selects and responses
   logic       gpio_cs;
   logic       sema_cs;
   logic       d2a_cs;
   reg_data_t  gpio_rdata;
   reg_data_t  sema_rdata;
   reg_data_t  d2a_rdata;
   logic       gpio_ack;
   logic       sema_ack;
   logic       d2a_ack;

   // Word offset shared by all blocks
   word_ofs_t  reg_ofs;

   // GPIO to pad mux
   pad_vec_t   cfg_gpio_dir_sel;
   pad_vec_t   gpio_out;
   pad_vec_t   cfg_multi_func_sel;
   pad_vec_t   pad_gpio_in;

   assign reg_ofs = reg_addr_i[2 +: WORD_OFS_W];

   // --------------------------------------
   // Block decoder
   // --------------------------------------
   reg_blk_decode u_decode (
      .mclk          (mclk),
      .s_reset_ssn   (s_reset_ssn),
      .reg_cs_i      (reg_cs_i),
      .reg_addr_i    (reg_addr_i),
      .gpio_rdata_i  (gpio_rdata),
      .gpio_ack_i    (gpio_ack),
      .sema_rdata_i  (sema_rdata),
      .sema_ack_i    (sema_ack),
      .d2a_rdata_i   (d2a_rdata),
      .d2a_ack_i     (d2a_ack),
      .gpio_cs_o     (gpio_cs),
      .sema_cs_o     (sema_cs),
      .d2a_cs_o      (d2a_cs),
      .reg_rdata_o   (reg_rdata_o),
      .reg_ack_o     (reg_ack_o)
   );

   // --------------------------------------
   // Register blocks
   // --------------------------------------
   gpio_reg u_gpio (
      .mclk                  (mclk),
      .s_reset_ssn           (s_reset_ssn),
      .reg_cs_i              (gpio_cs),
      .reg_wr_i              (reg_wr_i),
      .reg_ofs_i             (reg_ofs),
      .reg_wdata_i           (reg_wdata_i),
      .reg_be_i              (reg_be_i),
      .pad_gpio_in_i         (pad_gpio_in),
      .reg_rdata_o           (gpio_rdata),
      .reg_ack_o             (gpio_ack),
      .cfg_gpio_dir_sel_o    (cfg_gpio_dir_sel),
      .gpio_out_o            (gpio_out),
      .cfg_multi_func_sel_o  (cfg_multi_func_sel)
   );

   semaphore_reg u_sema (
      .mclk         (mclk),
      .s_reset_ssn  (s_reset_ssn),
      .reg_cs_i     (sema_cs),
      .reg_wr_i     (reg_wr_i),
      .reg_ofs_i    (reg_ofs),
      .reg_wdata_i  (reg_wdata_i),
      .reg_rdata_o  (sema_rdata),
      .reg_ack_o    (sema_ack)
   );

   dig2ana_reg u_d2a (
      .mclk               (mclk),
      .s_reset_ssn        (s_reset_ssn),
      .reg_cs_i           (d2a_cs),
      .reg_wr_i           (reg_wr_i),
      .reg_ofs_i          (reg_ofs),
      .reg_wdata_i        (reg_wdata_i),
      .reg_be_i           (reg_be_i),
      .reg_rdata_o        (d2a_rdata),
      .reg_ack_o          (d2a_ack),
      .cfg_dac_mux_sel_o  (cfg_dac_mux_sel_o)
   );

   // Pad multiplexer, combinational
   pad_mux u_pad_mux (
      .cfg_gpio_dir_sel_i    (cfg_gpio_dir_sel),
      .gpio_out_i            (gpio_out),
      .cfg_multi_func_sel_i  (cfg_multi_func_sel),
      .uart_txd_i            (uart_txd_i),
      .digital_io_in_i       (digital_io_in_i),
      .digital_io_out_o      (digital_io_out_o),
      .digital_io_oen_o      (digital_io_oen_o),
      .pad_gpio_in_o         (pad_gpio_in),
      .uart_rxd_o            (uart_rxd_o)
   );

endmodule

//--- sim/pinmux_tasks.svh
// Pinmux testbench tasks: register bus access, typed compares and directed tests
`ifndef PINMUX_TASKS_SVH
`define PINMUX_TASKS_SVH

// --------------------------------------
// Compare tasks
// --------------------------------------
task automatic check_data(input string name, input reg_data_t got, input reg_data_t exp);
   if (got !== exp) begin
      abort_run($sformatf("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp));
   end
endtask

task automatic check_pads(input string name, input pad_vec_t got, input pad_vec_t exp);
   if (got !== exp) begin
      abort_run($sformatf("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp));
   end
endtask

task automatic check_dac(input string name, input dac_sel_arr_t got, input dac_sel_arr_t exp);
   if (got !== exp) begin
      abort_run($sformatf("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp));
   end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
   if (got !== exp) begin
      abort_run($sformatf("[FAIL] t=%0t %s got %b expected %b", $time, name, got, exp));
   end
endtask

// --------------------------------------
// Register bus
// --------------------------------------
// Byte address from block code and word offset
function automatic logic [REG_ADDR_W-1:0] addr_of(input logic [BLK_SEL_W-1:0] blk,
                                                  input word_ofs_t ofs);
   return {blk, ofs, 2'b00};
endfunction

// Move to the next drive point, just after a rising edge
task automatic next_drive();
   @(posedge mclk);
   #0.5;
endtask

// One access, idle cycle before it, ack expected one cycle after cs is sampled
task automatic bus_access(input logic wr, input logic [BLK_SEL_W-1:0] blk,
                          input word_ofs_t ofs, input reg_data_t wdata,
                          input reg_be_t be, output reg_data_t rdata);
   int cycles;
   cycles = 0;
   next_drive();
   reg_cs    = 1'b1;
   reg_wr    = wr;
   reg_addr  = addr_of(blk, ofs);
   reg_wdata = wdata;
   reg_be    = be;
   // Sample ack away from the edge
   do begin
      @(posedge mclk);
      #1;
      cycles++;
   end while (!reg_ack && cycles < ACK_TIMEOUT);
   if (!reg_ack) begin
      abort_run($sformatf("No ack from block %0d within %0d cycles", blk, ACK_TIMEOUT));
   end else if (cycles != 1) begin
      abort_run($sformatf("Ack from block %0d came after %0d cycles, not 1", blk, cycles));
   end
   rdata = reg_rdata;
   // Drop cs in the cycle after the ack
   next_drive();
   reg_cs = 1'b0;
   reg_wr = 1'b0;
endtask

task automatic bus_write(input logic [BLK_SEL_W-1:0] blk, input word_ofs_t ofs,
                         input reg_data_t wdata, input reg_be_t be);
   reg_data_t unused;
   bus_access(1'b1, blk, ofs, wdata, be, unused);
endtask

task automatic bus_read(input logic [BLK_SEL_W-1:0] blk, input word_ofs_t ofs,
                        output reg_data_t rdata);
   bus_access(1'b0, blk, ofs, '0, '0, rdata);
endtask

// --------------------------------------
// Directed tests
// --------------------------------------
task automatic test_reset_state();
   reg_data_t rd;
   #1;
   check_pads("digital_io_oen_o", digital_io_oen, '1);
   check_dac("cfg_dac_mux_sel_o", cfg_dac_mux_sel, '0);
   check_bit("uart_rxd_o", uart_rxd, 1'b1);
   bus_read(SEL_SEMA, SEMA_STATUS_OFS, rd);
   check_data("reg_rdata_o", rd, '0);
endtask

task automatic test_gpio_io();
   reg_data_t rd;
   pad_vec_t  pads;
   exp_dir = pad_vec_t'($urandom);
   exp_out = pad_vec_t'($urandom);
   bus_write(SEL_GPIO, GPIO_DIR_OFS, reg_data_t'(exp_dir), 4'hf);
   bus_write(SEL_GPIO, GPIO_OUT_OFS, reg_data_t'(exp_out), 4'hf);
   #1;
   // Pad mux is combinational, pads follow at once
   check_pads("digital_io_out_o", digital_io_out, exp_out);
   check_pads("digital_io_oen_o", digital_io_oen, ~exp_dir);
   bus_read(SEL_GPIO, GPIO_DIR_OFS, rd);
   check_data("reg_rdata_o", rd, reg_data_t'(exp_dir));
   // Pads held for the synchronizer
   pads = pad_vec_t'($urandom);
   digital_io_in = pads;
   repeat (3) @(posedge mclk);
   #0.5;
   bus_read(SEL_GPIO, GPIO_IN_OFS, rd);
   check_data("reg_rdata_o", rd, reg_data_t'(pads));
endtask

task automatic test_uart_pads();
   pad_vec_t mask;
   pad_vec_t exp_pad_out;
   pad_vec_t exp_oen;
   // Output value of the RXD pad is not defined while it is an input
   mask = ~(pad_vec_t'(1) << UART_RXD_PAD);
   // GPIO direction opposite to the UART use, so both overrides show on oen
   exp_dir[UART_TXD_PAD] = 1'b0;
   exp_dir[UART_RXD_PAD] = 1'b1;
   bus_write(SEL_GPIO, GPIO_DIR_OFS, reg_data_t'(exp_dir), 4'hf);
   bus_write(SEL_GPIO, GPIO_MFS_OFS, reg_data_t'(1) << MFS_UART_BIT, 4'h1);
   for (int i = 0; i < 4; i++) begin
      next_drive();
      uart_txd = i[0];
      digital_io_in = pad_vec_t'($urandom);
      digital_io_in[UART_RXD_PAD] = i[1];
      #1;
      exp_pad_out = exp_out;
      exp_pad_out[UART_TXD_PAD] = i[0];
      exp_oen = ~exp_dir;
      exp_oen[UART_TXD_PAD] = 1'b0;
      exp_oen[UART_RXD_PAD] = 1'b1;
      check_pads("digital_io_out_o", digital_io_out & mask, exp_pad_out & mask);
      check_pads("digital_io_oen_o", digital_io_oen, exp_oen);
      check_bit("uart_rxd_o", uart_rxd, i[1]);
   end
   // Back to GPIO control
   bus_write(SEL_GPIO, GPIO_MFS_OFS, '0, 4'h1);
   #1;
   check_pads("digital_io_out_o", digital_io_out, exp_out);
   check_pads("digital_io_oen_o", digital_io_oen, ~exp_dir);
   check_bit("uart_rxd_o", uart_rxd, 1'b1);
endtask

task automatic test_semaphores();
   int        n;
   reg_data_t rd;
   n = 1 + int'($urandom % SEMA_COUNT);
   bus_read(SEL_SEMA, word_ofs_t'(n), rd);
   check_data("reg_rdata_o", rd, 32'h1);
   // Already taken
   bus_read(SEL_SEMA, word_ofs_t'(n), rd);
   check_data("reg_rdata_o", rd, 32'h0);
   bus_read(SEL_SEMA, SEMA_STATUS_OFS, rd);
   check_data("reg_rdata_o", rd, reg_data_t'(1) << n);
   bus_write(SEL_SEMA, word_ofs_t'(n), 32'h1, 4'hf);
   bus_read(SEL_SEMA, word_ofs_t'(n), rd);
   check_data("reg_rdata_o", rd, 32'h1);
   // Leave it free
   bus_write(SEL_SEMA, word_ofs_t'(n), 32'h1, 4'hf);
   bus_read(SEL_SEMA, SEMA_STATUS_OFS, rd);
   check_data("reg_rdata_o", rd, '0);
endtask

task automatic test_dac_selects();
   dac_sel_arr_t exp_sel;
   reg_data_t    wdata;
   reg_be_t      be;
   reg_data_t    rd;
   exp_sel = '0;
   for (int i = 0; i < 6; i++) begin
      wdata = $urandom;
      be    = reg_be_t'($urandom);
      bus_write(SEL_D2A, D2A_SEL_OFS, wdata, be);
      // Only enabled bytes change
      for (int k = 0; k < DAC_COUNT; k++) begin
         if (be[k]) begin
            exp_sel[k] = wdata[k*DAC_SEL_W +: DAC_SEL_W];
         end
      end
      #1;
      check_dac("cfg_dac_mux_sel_o", cfg_dac_mux_sel, exp_sel);
      bus_read(SEL_D2A, D2A_SEL_OFS, rd);
      check_data("reg_rdata_o", rd, reg_data_t'(exp_sel));
   end
endtask

task automatic test_unmapped_block();
   reg_data_t rd;
   bus_write(BLK_UNMAPPED, word_ofs_t'(1), $urandom, 4'hf);
   bus_read(BLK_UNMAPPED, word_ofs_t'(0), rd);
   check_data("reg_rdata_o", rd, '0);
   bus_read(BLK_UNMAPPED, word_ofs_t'(1), rd);
   check_data("reg_rdata_o", rd, '0);
endtask

`endif

//--- sim/pinmux_tb.sv
// Pinmux testbench top: clock, reset, DUT instance and directed test sequence
`timescale 1ns/10ps

module pinmux_tb;

   import reg_bus_pkg::*;
   import pad_pkg::*;

   // --------------------------------------
   // Run constants
   // --------------------------------------
   localparam int          RESET_CYCLES = 10;
   // Cycles to wait for an ack before giving up
   localparam int          ACK_TIMEOUT  = 16;
   localparam logic [31:0] SEED         = 32'h7905;
   // Block code with nothing behind it
   localparam logic [BLK_SEL_W-1:0] BLK_UNMAPPED = 3'd7;

   logic                    mclk;
   logic                    s_reset_ssn;
   logic                    reg_cs;
   logic                    reg_wr;
   logic [REG_ADDR_W-1:0]   reg_addr;
   reg_data_t               reg_wdata;
   reg_be_t                 reg_be;
   reg_data_t               reg_rdata;
   logic                    reg_ack;
   pad_vec_t                digital_io_in;
   pad_vec_t                digital_io_out;
   pad_vec_t                digital_io_oen;
   logic                    uart_txd;
   logic                    uart_rxd;
   dac_sel_arr_t            cfg_dac_mux_sel;

   // Expected GPIO register contents
   pad_vec_t                exp_dir;
   pad_vec_t                exp_out;

   // 4 ns period
   always #2 mclk = ~mclk;

   pinmux_top i_dut (
      .mclk               (mclk),
      .s_reset_ssn        (s_reset_ssn),
      .reg_cs_i           (reg_cs),
      .reg_wr_i           (reg_wr),
      .reg_addr_i         (reg_addr),
      .reg_wdata_i        (reg_wdata),
      .reg_be_i           (reg_be),
      .reg_rdata_o        (reg_rdata),
      .reg_ack_o          (reg_ack),
      .digital_io_in_i    (digital_io_in),
      .digital_io_out_o   (digital_io_out),
      .digital_io_oen_o   (digital_io_oen),
      .uart_txd_i         (uart_txd),
      .uart_rxd_o         (uart_rxd),
      .cfg_dac_mux_sel_o  (cfg_dac_mux_sel)
   );

   // Report the reason, then end the run
   task automatic abort_run(input string why);
      $display("%s", why);
      $display("TEST RESULT: FAIL");
      $fatal(1, "simulation stopped at the first error");
   endtask

   `include "pinmux_tasks.svh"

   // --------------------------------------
   // Test sequence
   // --------------------------------------
   initial begin
      mclk          = 1'b0;
      s_reset_ssn   = 1'b0;
      reg_cs        = 1'b0;
      reg_wr        = 1'b0;
      reg_addr      = '0;
      reg_wdata     = '0;
      reg_be        = '0;
      digital_io_in = '0;
      uart_txd      = 1'b1;
      exp_dir       = '0;
      exp_out       = '0;
      void'($urandom(SEED));

      repeat (RESET_CYCLES) @(posedge mclk);
      #0.5;
      s_reset_ssn = 1'b1;

      test_reset_state();
      test_gpio_io();
      test_uart_pads();
      test_semaphores();
      test_dac_selects();
      test_unmapped_block();

      $display("TEST RESULT: PASS");
      $finish;
   end

endmodule

//--- pinmux_top.f
hw/reg_bus_pkg.sv
hw/pad_pkg.sv
hw/reg_blk_decode.sv
hw/gpio_reg.sv
hw/pad_mux.sv
hw/semaphore_reg.sv
hw/dig2ana_reg.sv
hw/pinmux_top.sv
+incdir+sim
sim/pinmux_tb.sv
